// ==== compile.f ====
hw/isa_pkg.sv
hw/fwd_pkg.sv
hw/register_file.sv
hw/operand_select.sv
hw/issue_align.sv
hw/register_fetch.sv
dv/register_fetch_checker.sv
dv/register_fetch_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vregister_fetch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module register_fetch_tb -f compile.f

run: build
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing --assert --top-module register_fetch_tb -f compile.f

clean:
	rm -rf obj_dir

// ==== dv/register_fetch_tb.sv ====
`timescale 1ns/1ns

module register_fetch_tb;
  import isa_pkg::*;
  import fwd_pkg::*;

  localparam int SEED           = 32'h79c140d0;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int WR_RD_ROUNDS   = 8;
  localparam int STREAM_CYCLES  = 100;

  // who should supply the operand in a priority case
  localparam int WIN_OWN   = 0;
  localparam int WIN_OTHER = 1;
  localparam int WIN_REG   = 2;

  typedef issue_bundle_t [0:NUM_PIPES-1] issue_pair_t;

  logic                           clk;
  logic                           rst;
  instr_info_t [0:NUM_PIPES-1]    instr_in;
  src_addrs_t  [0:NUM_PIPES-1]    src_addr;
  write_port_t [0:NUM_WR_PORTS-1] wr_port;
  stage_set_t  [0:NUM_PIPES-1]    stages;
  issue_pair_t                    issue;

  // inputs for the next edge as the tests fill them in
  instr_info_t [0:NUM_PIPES-1]    nxt_instr;
  src_addrs_t  [0:NUM_PIPES-1]    nxt_src;
  write_port_t [0:NUM_WR_PORTS-1] nxt_wr;
  stage_set_t  [0:NUM_PIPES-1]    nxt_stages;

  quad_t       model_regs [NUM_REGS];
  issue_pair_t exp_q [$];
  integer      seed;
  int          cycle_count = 0;

  register_fetch register_fetch_inst (
    .clk      (clk),
    .rst      (rst),
    .instr_in (instr_in),
    .src_addr (src_addr),
    .wr_port  (wr_port),
    .stages   (stages),
    .issue    (issue)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic quad_t rand_quad();
    return {rand32(), rand32(), rand32(), rand32()};
  endfunction

  // narrow range makes forwarding hits frequent
  function automatic reg_addr_t rand_addr(bit narrow);
    logic [31:0] r;
    r = rand32();
    if (narrow) begin
      return {4'b0000, r[2:0]};
    end
    return r[6:0];
  endfunction

  function automatic instr_info_t rand_instr();
    logic [63:0] r;
    r = {rand32(), rand32()};
    return r[53:0];
  endfunction

  function automatic stage_result_t rand_record();
    stage_result_t rec;
    logic [31:0]   r;
    r = rand32();
    rec.result  = rand_quad();
    rec.reg_dst = {4'b0000, r[2:0]};
    rec.reg_wr  = r[8];
    return rec;
  endfunction

  // youngest stage first, own pipe ahead of the other one at equal depth
  function automatic quad_t operand_for(int p, reg_addr_t addr);
    stage_set_t own;
    stage_set_t other;
    own   = nxt_stages[p];
    other = nxt_stages[(p + 1) % NUM_PIPES];
    for (int s = 0; s < NUM_FWD_STAGES; s++) begin
      if (own[s].reg_wr && own[s].reg_dst == addr) begin
        return own[s].result;
      end
      if (other[s].reg_wr && other[s].reg_dst == addr) begin
        return other[s].result;
      end
    end
    return model_regs[addr];
  endfunction

  function automatic issue_pair_t predict_issue();
    issue_pair_t exp;
    for (int p = 0; p < NUM_PIPES; p++) begin
      exp[p].info    = nxt_instr[p];
      exp[p].ra_data = operand_for(p, nxt_src[p].ra);
      exp[p].rb_data = operand_for(p, nxt_src[p].rb);
      exp[p].rc_data = operand_for(p, nxt_src[p].rc);
    end
    return exp;
  endfunction

  // second port last, so it wins a shared address
  task automatic commit_writes();
    for (int w = 0; w < NUM_WR_PORTS; w++) begin
      if (nxt_wr[w].en) begin
        model_regs[nxt_wr[w].addr] = nxt_wr[w].data;
      end
    end
  endtask

  task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH at time %0t: %s expected %h actual %h",
               $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_issue(issue_pair_t exp);
    for (int p = 0; p < NUM_PIPES; p++) begin
      check_value($sformatf("issue[%0d].info", p), 128'(exp[p].info), 128'(issue[p].info));
      check_value($sformatf("issue[%0d].ra_data", p), exp[p].ra_data, issue[p].ra_data);
      check_value($sformatf("issue[%0d].rb_data", p), exp[p].rb_data, issue[p].rb_data);
      check_value($sformatf("issue[%0d].rc_data", p), exp[p].rc_data, issue[p].rc_data);
    end
  endtask

  task automatic clear_inputs();
    nxt_instr  = '0;
    nxt_src    = '0;
    nxt_wr     = '0;
    nxt_stages = '0;
  endtask

  // one edge of stimulus and a check of the bundle from two edges back
  task automatic step();
    issue_pair_t exp_now;
    issue_pair_t oldest;
    @(posedge clk);
    instr_in <= nxt_instr;
    src_addr <= nxt_src;
    wr_port  <= nxt_wr;
    stages   <= nxt_stages;
    exp_now = predict_issue();
    commit_writes();
    exp_q.push_back(exp_now);
    @(negedge clk);
    if (exp_q.size() > 2) begin
      oldest = exp_q.pop_front();
      check_issue(oldest);
    end
  endtask

  // afterwards issue shows the last step taken before this
  task automatic drain();
    clear_inputs();
    step();
    step();
  endtask

  task automatic test_reset();
    issue_pair_t zero;
    zero = '0;
    @(negedge clk);
    check_issue(zero);
    clear_inputs();
    for (int p = 0; p < NUM_PIPES; p++) begin
      nxt_src[p].ra = rand_addr(1'b0);
      nxt_src[p].rb = rand_addr(1'b0);
      nxt_src[p].rc = rand_addr(1'b0);
    end
    step();
    drain();
    check_issue(zero);
  endtask

  task automatic test_write_read();
    reg_addr_t   a0;
    reg_addr_t   a1;
    quad_t       d0;
    quad_t       d1;
    instr_info_t info;
    for (int i = 0; i < WR_RD_ROUNDS; i++) begin
      a0 = rand_addr(1'b0);
      a1 = a0 ^ 7'h55;
      d0 = rand_quad();
      d1 = rand_quad();
      clear_inputs();
      nxt_wr[0] = '{1'b1, a0, d0};
      nxt_wr[1] = '{1'b1, a1, d1};
      step();
      info = rand_instr();
      clear_inputs();
      nxt_instr[0]  = info;
      nxt_src[0].ra = a0;
      nxt_src[1].rc = a1;
      step();
      drain();
      check_value("issue[0].info", 128'(info), 128'(issue[0].info));
      check_value("issue[0].ra_data", d0, issue[0].ra_data);
      check_value("issue[1].rc_data", d1, issue[1].rc_data);
    end
  endtask

  task automatic test_write_conflict();
    reg_addr_t a;
    quad_t     old_val;
    quad_t     d0;
    quad_t     d1;
    a       = rand_addr(1'b0);
    old_val = rand_quad();
    d0      = rand_quad();
    d1      = rand_quad();
    clear_inputs();
    nxt_wr[0] = '{1'b1, a, old_val};
    step();
    clear_inputs();
    nxt_wr[0]     = '{1'b1, a, d0};
    nxt_wr[1]     = '{1'b1, a, d1};
    nxt_src[0].ra = a;
    step();
    clear_inputs();
    nxt_src[1].rb = a;
    step();
    clear_inputs();
    step();
    // read made alongside both writes
    check_value("issue[0].ra_data", old_val, issue[0].ra_data);
    step();
    check_value("issue[1].rb_data", d1, issue[1].rb_data);
  endtask

  task automatic priority_case(int tp, int own_s, logic own_wr, int other_s, logic other_wr,
                               int winner, reg_addr_t t, quad_t reg_val);
    int    op;
    quad_t own_val;
    quad_t other_val;
    quad_t expected;
    op        = (tp + 1) % NUM_PIPES;
    own_val   = rand_quad();
    other_val = rand_quad();
    clear_inputs();
    nxt_stages[tp][own_s]  = '{own_val, t, own_wr};
    nxt_stages[op][other_s] = '{other_val, t, other_wr};
    // younger writer of a different register
    if (own_s > 0) begin
      nxt_stages[tp][0] = '{rand_quad(), t ^ 7'h01, 1'b1};
    end
    nxt_src[tp].ra = t;
    step();
    drain();
    case (winner)
      WIN_OWN:   expected = own_val;
      WIN_OTHER: expected = other_val;
      default:   expected = reg_val;
    endcase
    check_value($sformatf("issue[%0d].ra_data", tp), expected, issue[tp].ra_data);
  endtask

  task automatic test_fwd_priority();
    reg_addr_t t;
    quad_t     reg_val;
    t       = rand_addr(1'b0);
    reg_val = rand_quad();
    clear_inputs();
    nxt_wr[1] = '{1'b1, t, reg_val};
    step();
    for (int tp = 0; tp < NUM_PIPES; tp++) begin
      priority_case(tp, 3, 1'b1, 1, 1'b1, WIN_OTHER, t, reg_val);
      priority_case(tp, 2, 1'b1, 2, 1'b1, WIN_OWN, t, reg_val);
      priority_case(tp, 0, 1'b0, 3, 1'b1, WIN_OTHER, t, reg_val);
      priority_case(tp, 1, 1'b0, 1, 1'b0, WIN_REG, t, reg_val);
      priority_case(tp, 5, 1'b1, 5, 1'b1, WIN_OWN, t, reg_val);
      priority_case(tp, 4, 1'b1, 0, 1'b0, WIN_OWN, t, reg_val);
    end
  endtask

  task automatic test_streaming();
    logic [31:0] r;
    for (int i = 0; i < STREAM_CYCLES; i++) begin
      for (int p = 0; p < NUM_PIPES; p++) begin
        nxt_instr[p]  = rand_instr();
        nxt_src[p].ra = rand_addr(1'b1);
        nxt_src[p].rb = rand_addr(1'b1);
        nxt_src[p].rc = rand_addr(1'b1);
        for (int s = 0; s < NUM_FWD_STAGES; s++) begin
          nxt_stages[p][s] = rand_record();
        end
      end
      for (int w = 0; w < NUM_WR_PORTS; w++) begin
        r = rand32();
        nxt_wr[w] = '{r[0], rand_addr(1'b1), rand_quad()};
      end
      step();
    end
    drain();
  endtask

  initial begin
    seed     = SEED;
    rst      = 1'b1;
    instr_in = '0;
    src_addr = '0;
    wr_port  = '0;
    stages   = '0;
    clear_inputs();
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_write_read();
    test_write_conflict();
    test_fwd_priority();
    test_streaming();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== dv/register_fetch_checker.sv ====
`timescale 1ns/1ns

module register_fetch_checker (
  input logic                                          clk,
  input logic                                          rst,
  input isa_pkg::instr_info_t   [0:fwd_pkg::NUM_PIPES-1] instr_in,
  input isa_pkg::issue_bundle_t [0:fwd_pkg::NUM_PIPES-1] issue
);
  import fwd_pkg::*;

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_pipe
    // nothing may claim a register write while reset is held
    assert property (@(posedge clk) rst |-> !issue[p].info.reg_wr)
      else $error("issue[%0d] register-write flag set during reset", p);

    // info leaves exactly two cycles after it was taken
    assert property (@(posedge clk) disable iff (rst)
      (!$past(rst, 1) && !$past(rst, 2)) |-> (issue[p].info == $past(instr_in[p], 2)))
      else $error("issue[%0d] info does not match instr_in from two cycles earlier", p);
  end

  assert property (@(posedge clk) disable iff (rst) !$isunknown(issue))
    else $error("issue carries unknown bits after reset");

endmodule

bind register_fetch register_fetch_checker register_fetch_checker_inst (
  .clk      (clk),
  .rst      (rst),
  .instr_in (instr_in),
  .issue    (issue)
);

// ==== hw/register_fetch.sv ====
`timescale 1ns/1ns

module register_fetch (
  input  logic                                          clk,
  input  logic                                          rst,
  input  isa_pkg::instr_info_t   [0:fwd_pkg::NUM_PIPES-1]    instr_in,
  input  isa_pkg::src_addrs_t    [0:fwd_pkg::NUM_PIPES-1]    src_addr,
  input  isa_pkg::write_port_t   [0:isa_pkg::NUM_WR_PORTS-1] wr_port,
  input  fwd_pkg::stage_set_t    [0:fwd_pkg::NUM_PIPES-1]    stages,
  output isa_pkg::issue_bundle_t [0:fwd_pkg::NUM_PIPES-1]    issue
);
  import isa_pkg::*;
  import fwd_pkg::*;

  // flat source index is pipe * 3 + slot
  wire reg_addr_t [0:NUM_SRC-1] rd_addr;
  wire quad_t     [0:NUM_SRC-1] rf_data;
  wire quad_t     [0:NUM_SRC-1] operand;

  register_file register_file_inst (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr_port),
    .rd_addr (rd_addr),
    .rd_data (rf_data)
  );

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_pipe
    assign rd_addr[p * SRC_PER_PIPE + SRC_RA] = src_addr[p].ra;
    assign rd_addr[p * SRC_PER_PIPE + SRC_RB] = src_addr[p].rb;
    assign rd_addr[p * SRC_PER_PIPE + SRC_RC] = src_addr[p].rc;

    for (genvar s = 0; s < SRC_PER_PIPE; s++) begin : g_src
      // own pipe plus the other pipe for cross forwarding
      operand_select operand_select_inst (
        .clk          (clk),
        .rst          (rst),
        .src          (rd_addr[p * SRC_PER_PIPE + s]),
        .rf_data      (rf_data[p * SRC_PER_PIPE + s]),
        .own_stages   (stages[p]),
        .other_stages (stages[(p + 1) % NUM_PIPES]),
        .operand      (operand[p * SRC_PER_PIPE + s])
      );
    end
  end

  issue_align issue_align_inst (
    .clk      (clk),
    .rst      (rst),
    .instr_in (instr_in),
    .operand  (operand),
    .issue    (issue)
  );

endmodule

// ==== hw/issue_align.sv ====
`timescale 1ns/1ns

module issue_align (
  input  logic                                          clk,
  input  logic                                          rst,
  input  isa_pkg::instr_info_t   [0:fwd_pkg::NUM_PIPES-1] instr_in,
  input  isa_pkg::quad_t         [0:fwd_pkg::NUM_SRC-1]   operand,
  output isa_pkg::issue_bundle_t [0:fwd_pkg::NUM_PIPES-1] issue
);
  import isa_pkg::*;
  import fwd_pkg::*;

  // instruction info waits here while operands are selected
  instr_info_t   [0:NUM_PIPES-1] info_q;
  issue_bundle_t [0:NUM_PIPES-1] issue_d;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      info_q <= '0;
    end else begin
      info_q <= instr_in;
    end
  end

  // pack each pipe's bundle from its three operand slots
  always_comb begin
    for (int p = 0; p < NUM_PIPES; p++) begin
      issue_d[p].info    = info_q[p];
      issue_d[p].ra_data = operand[p * SRC_PER_PIPE + SRC_RA];
      issue_d[p].rb_data = operand[p * SRC_PER_PIPE + SRC_RB];
      issue_d[p].rc_data = operand[p * SRC_PER_PIPE + SRC_RC];
    end
  end

  // second stage where info and operands leave together
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      issue <= '0;
    end else begin
      issue <= issue_d;
    end
  end

endmodule

// ==== hw/operand_select.sv ====
`timescale 1ns/1ns

module operand_select (
  input  logic                clk,
  input  logic                rst,
  input  isa_pkg::reg_addr_t  src,
  input  isa_pkg::quad_t      rf_data,
  input  fwd_pkg::stage_set_t own_stages,
  input  fwd_pkg::stage_set_t other_stages,
  output isa_pkg::quad_t      operand
);
  import isa_pkg::*;
  import fwd_pkg::*;

  logic [0:NUM_FWD_STAGES-1] own_hit;
  logic [0:NUM_FWD_STAGES-1] other_hit;
  logic                      fwd_found;
  quad_t                     sel_data;

  // a record forwards only when it actually writes the source register
  function automatic logic stage_match(stage_result_t rec, reg_addr_t addr);
    return rec.reg_wr && (rec.reg_dst == addr);
  endfunction

  always_comb begin
    for (int s = 0; s < NUM_FWD_STAGES; s++) begin
      own_hit[s]   = stage_match(own_stages[s], src);
      other_hit[s] = stage_match(other_stages[s], src);
    end
  end

  // youngest stage first, own pipe ahead of the other pipe
  always_comb begin
    fwd_found = 1'b0;
    sel_data  = rf_data;
    for (int s = 0; s < NUM_FWD_STAGES; s++) begin
      if (!fwd_found) begin
        if (own_hit[s]) begin
          sel_data  = own_stages[s].result;
          fwd_found = 1'b1;
        end else if (other_hit[s]) begin
          sel_data  = other_stages[s].result;
          fwd_found = 1'b1;
        end
      end
    end
  end

  // first operand register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      operand <= '0;
    end else begin
      operand <= sel_data;
    end
  end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ns

module register_file (
  input  logic                                               clk,
  input  logic                                               rst,
  input  isa_pkg::write_port_t [0:isa_pkg::NUM_WR_PORTS-1]   wr,
  input  isa_pkg::reg_addr_t   [0:fwd_pkg::NUM_SRC-1]        rd_addr,
  output isa_pkg::quad_t       [0:fwd_pkg::NUM_SRC-1]        rd_data
);
  import isa_pkg::*;
  import fwd_pkg::*;

  quad_t regs [NUM_REGS];

  // writes land on the edge, so a read in the same cycle still sees the old value
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // port 2 is applied last and wins a shared address
      for (int w = 0; w < NUM_WR_PORTS; w++) begin
        if (wr[w].en) begin
          regs[wr[w].addr] <= wr[w].data;
        end
      end
    end
  end

  // six independent read ports
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      rd_data[i] = regs[rd_addr[i]];
    end
  end

endmodule

// ==== hw/fwd_pkg.sv ====
package fwd_pkg;

  // pipe 0 is even, pipe 1 is odd
  localparam int NUM_PIPES    = 2;
  localparam int SRC_PER_PIPE = 3;
  localparam int NUM_SRC      = NUM_PIPES * SRC_PER_PIPE;

  // slot of each source inside a pipe
  localparam int SRC_RA = 0;
  localparam int SRC_RB = 1;
  localparam int SRC_RC = 2;

  // execution stages that can forward a result
  localparam int FIRST_FWD_STAGE = 2;
  localparam int LAST_FWD_STAGE  = 7;
  localparam int NUM_FWD_STAGES  = LAST_FWD_STAGE - FIRST_FWD_STAGE + 1;

  // in-flight result of one execution stage
  typedef struct packed {
    isa_pkg::quad_t     result;
    isa_pkg::reg_addr_t reg_dst;
    logic               reg_wr;
  } stage_result_t;

  // index 0 is the youngest stage
  typedef stage_result_t [0:NUM_FWD_STAGES-1] stage_set_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

  // register file geometry
  localparam int REG_ADDR_W   = 7;
  localparam int QUAD_W       = 128;
  localparam int NUM_REGS     = 128;
  localparam int NUM_WR_PORTS = 2;

  // decoded instruction field widths
  localparam int INSTR_W     = 32;
  localparam int INSTR_NUM_W = 7;
  localparam int UNIT_ID_W   = 3;
  localparam int LATENCY_W   = 4;

  typedef logic [0:REG_ADDR_W-1]  reg_addr_t;
  typedef logic [0:QUAD_W-1]      quad_t;
  typedef logic [0:INSTR_W-1]     instr_word_t;
  typedef logic [0:INSTR_NUM_W-1] instr_num_t;
  typedef logic [0:UNIT_ID_W-1]   unit_id_t;
  typedef logic [0:LATENCY_W-1]   latency_t;

  // decoded instruction as handed over by decode (54 bits)
  typedef struct packed {
    instr_word_t full_instr;
    instr_num_t  instr_num;
    reg_addr_t   reg_dst;
    unit_id_t    unit_id;
    latency_t    latency;
    logic        reg_wr;
  } instr_info_t;

  // three source addresses of one instruction
  typedef struct packed {
    reg_addr_t ra;
    reg_addr_t rb;
    reg_addr_t rc;
  } src_addrs_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    quad_t     data;
  } write_port_t;

  // what one pipe hands to execute
  typedef struct packed {
    instr_info_t info;
    quad_t       ra_data;
    quad_t       rb_data;
    quad_t       rc_data;
  } issue_bundle_t;

endpackage
